//--- logic/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address into main memory
`define MEM_ADDR_WIDTH 12

// RAM size in bytes
`define MEM_DEPTH 4096

// one instruction word is read as this many bytes
`define INST_BYTES 4

`endif

//--- logic/memTypesPkg.sv
`include "mem_defines.svh"

package memTypesPkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;

    typedef logic [7:0] byteT;

    typedef logic [31:0] instT;

    typedef logic [31:0] dataT;

    // 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } accessLenT;

    typedef enum logic {
        KIND_LOAD  = 1'b0,
        KIND_STORE = 1'b1
    } accessKindT;

endpackage

//--- logic/arbTypesPkg.sv
package arbTypesPkg;

    // who holds the single RAM port
    typedef enum logic [1:0] {
        OWNER_NONE  = 2'd0,
        OWNER_FETCH = 2'd1,
        OWNER_DATA  = 2'd2
    } ownerT;

endpackage

//--- logic/byteCollector.sv
`timescale 1ns/1ns

module byteCollector import memTypesPkg::*; #(
    parameter type payloadT = dataT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       capture,
    input  logic [1:0] byteIndex,
    input  byteT       inByte,
    output payloadT    payload
);

    // lanes never written stay zero, so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            payload <= '0;
        end else if (capture) begin
            // little-endian, lane 0 is the lowest address
            payload[{byteIndex, 3'b000} +: 8] <= inByte;
        end
    end

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module fetchUnit import memTypesPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic fetchReq,
    input  addrT fetchAddr,
    output logic fetchAck,
    output instT fetchInst,
    output logic busReq,
    input  logic step,
    output addrT reqAddr,
    input  byteT ramRdata
);

    logic [1:0] byteCnt;
    logic       busy;
    logic       readPending;
    logic       start;
    logic       lastStep;

    // new request only once the previous ack has dropped
    assign start = fetchReq && !busy && !fetchAck;
    assign lastStep = step && (byteCnt == 2'(`INST_BYTES - 1));
    assign reqAddr = fetchAddr + addrT'(byteCnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            busReq      <= 1'b0;
            byteCnt     <= 2'd0;
            readPending <= 1'b0;
            fetchAck    <= 1'b0;
        end else begin
            // RAM answers one cycle after the read step
            readPending <= step;

            if (start) begin
                busy    <= 1'b1;
                busReq  <= 1'b1;
                byteCnt <= 2'd0;
            end else if (busReq && step) begin
                byteCnt <= byteCnt + 2'd1;
                if (lastStep) begin
                    busReq <= 1'b0;
                end
            end

            // last byte lands in the collector on this edge
            if (busy && !busReq && readPending) begin
                busy     <= 1'b0;
                fetchAck <= 1'b1;
            end else if (fetchAck && !fetchReq) begin
                fetchAck <= 1'b0;
            end
        end
    end

    byteCollector #(
        .payloadT(instT)
    ) instCollector_i (
        .clk      (clk),
        .rst      (rst),
        .clear    (start),
        .capture  (readPending),
        .byteIndex(byteCnt - 2'd1),
        .inByte   (ramRdata),
        .payload  (fetchInst)
    );

endmodule

//--- logic/loadStoreUnit.sv
`timescale 1ns/1ns

module loadStoreUnit import memTypesPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       dataReq,
    input  accessKindT dataKind,
    input  accessLenT  dataLen,
    input  addrT       dataAddr,
    input  dataT       dataWdata,
    output logic       dataAck,
    output dataT       dataRdata,
    output logic       busReq,
    input  logic       step,
    output addrT       reqAddr,
    output logic       reqWrite,
    output byteT       reqWdata,
    input  byteT       ramRdata
);

    logic [1:0] byteCnt;
    logic [1:0] lastIndex;
    logic       busy;
    logic       readPending;
    logic       start;
    logic       lastStep;

    // index of the final byte of the access
    always_comb begin
        case (dataLen)
            LEN_BYTE: lastIndex = 2'd0;
            LEN_HALF: lastIndex = 2'd1;
            default:  lastIndex = 2'd3;
        endcase
    end

    assign start = dataReq && !busy && !dataAck;
    assign lastStep = step && (byteCnt == lastIndex);
    assign reqAddr = dataAddr + addrT'(byteCnt);
    assign reqWrite = (dataKind == KIND_STORE);
    assign reqWdata = dataWdata[{byteCnt, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            busReq      <= 1'b0;
            byteCnt     <= 2'd0;
            readPending <= 1'b0;
            dataAck     <= 1'b0;
        end else begin
            readPending <= step && !reqWrite;

            if (start) begin
                busy    <= 1'b1;
                busReq  <= 1'b1;
                byteCnt <= 2'd0;
            end else if (busReq && step) begin
                byteCnt <= byteCnt + 2'd1;
                if (lastStep) begin
                    busReq <= 1'b0;
                end
            end

            // stores finish on the last write, loads one cycle later
            if (lastStep && reqWrite) begin
                busy    <= 1'b0;
                dataAck <= 1'b1;
            end else if (busy && !busReq && readPending) begin
                busy    <= 1'b0;
                dataAck <= 1'b1;
            end else if (dataAck && !dataReq) begin
                dataAck <= 1'b0;
            end
        end
    end

    byteCollector #(
        .payloadT(dataT)
    ) dataCollector_i (
        .clk      (clk),
        .rst      (rst),
        .clear    (start),
        .capture  (readPending),
        .byteIndex(byteCnt - 2'd1),
        .inByte   (ramRdata),
        .payload  (dataRdata)
    );

endmodule

//--- logic/memArbiter.sv
`timescale 1ns/1ns

module memArbiter import memTypesPkg::*, arbTypesPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic fetchBusReq,
    input  addrT fetchAddr,
    input  logic dataBusReq,
    input  addrT dataAddr,
    input  logic dataWrite,
    input  byteT dataWdata,
    output logic fetchStep,
    output logic dataStep,
    output addrT ramAddr,
    output logic ramWrite,
    output byteT ramWdata
);

    ownerT owner;

    // grant held until the owner lets go of busReq
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWNER_NONE;
        end else begin
            case (owner)
                OWNER_NONE: begin
                    // data side wins a tie
                    if (dataBusReq) begin
                        owner <= OWNER_DATA;
                    end else if (fetchBusReq) begin
                        owner <= OWNER_FETCH;
                    end
                end
                OWNER_FETCH: begin
                    if (!fetchBusReq) begin
                        owner <= OWNER_NONE;
                    end
                end
                OWNER_DATA: begin
                    if (!dataBusReq) begin
                        owner <= OWNER_NONE;
                    end
                end
                default: owner <= OWNER_NONE;
            endcase
        end
    end

    // no byte moves while stalled
    assign fetchStep = (owner == OWNER_FETCH) && fetchBusReq && !stall;
    assign dataStep = (owner == OWNER_DATA) && dataBusReq && !stall;

    assign ramAddr = (owner == OWNER_DATA) ? dataAddr : fetchAddr;
    assign ramWdata = (owner == OWNER_DATA) ? dataWdata : '0;
    assign ramWrite = dataStep && dataWrite;

endmodule

//--- logic/byteRam.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module byteRam import memTypesPkg::*; (
    input  logic clk,
    input  addrT ramAddr,
    input  logic ramWrite,
    input  byteT ramWdata,
    output byteT ramRdata
);

    byteT mem [`MEM_DEPTH];

    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramAddr] <= ramWdata;
        end else begin
            ramRdata <= mem[ramAddr];
        end
    end

endmodule

//--- logic/memCtrlTop.sv
`timescale 1ns/1ns

module memCtrlTop import memTypesPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       fetchReq,
    input  addrT       fetchAddr,
    output logic       fetchAck,
    output instT       fetchInst,
    input  logic       dataReq,
    input  accessKindT dataKind,
    input  accessLenT  dataLen,
    input  addrT       dataAddr,
    input  dataT       dataWdata,
    output logic       dataAck,
    output dataT       dataRdata
);

    logic fetchBusReq;
    logic fetchStep;
    addrT fetchReqAddr;
    logic dataBusReq;
    logic dataStep;
    addrT dataReqAddr;
    logic dataReqWrite;
    byteT dataReqWdata;
    addrT ramAddr;
    logic ramWrite;
    byteT ramWdata;
    byteT ramRdata;

    fetchUnit fetchUnit_i (
        .clk      (clk),
        .rst      (rst),
        .fetchReq (fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck (fetchAck),
        .fetchInst(fetchInst),
        .busReq   (fetchBusReq),
        .step     (fetchStep),
        .reqAddr  (fetchReqAddr),
        .ramRdata (ramRdata)
    );

    loadStoreUnit loadStoreUnit_i (
        .clk      (clk),
        .rst      (rst),
        .dataReq  (dataReq),
        .dataKind (dataKind),
        .dataLen  (dataLen),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .dataAck  (dataAck),
        .dataRdata(dataRdata),
        .busReq   (dataBusReq),
        .step     (dataStep),
        .reqAddr  (dataReqAddr),
        .reqWrite (dataReqWrite),
        .reqWdata (dataReqWdata),
        .ramRdata (ramRdata)
    );

    memArbiter memArbiter_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .fetchBusReq(fetchBusReq),
        .fetchAddr  (fetchReqAddr),
        .dataBusReq (dataBusReq),
        .dataAddr   (dataReqAddr),
        .dataWrite  (dataReqWrite),
        .dataWdata  (dataReqWdata),
        .fetchStep  (fetchStep),
        .dataStep   (dataStep),
        .ramAddr    (ramAddr),
        .ramWrite   (ramWrite),
        .ramWdata   (ramWdata)
    );

    byteRam byteRam_i (
        .clk     (clk),
        .ramAddr (ramAddr),
        .ramWrite(ramWrite),
        .ramWdata(ramWdata),
        .ramRdata(ramRdata)
    );

endmodule

//--- dv/memCtrlTb.sv
`timescale 1ns/1ns
`include "mem_defines.svh"

module memCtrlTb import memTypesPkg::*, arbTypesPkg::*; ();

    localparam int WAIT_LIMIT = 100;

    logic       clk;
    logic       rst;
    logic       stall;
    logic       fetchReq;
    addrT       fetchAddr;
    logic       fetchAck;
    instT       fetchInst;
    logic       dataReq;
    accessKindT dataKind;
    accessLenT  dataLen;
    addrT       dataAddr;
    dataT       dataWdata;
    logic       dataAck;
    dataT       dataRdata;

    // expected RAM contents, kept up to date by every store
    byteT        refMem [`MEM_DEPTH];
    logic [31:0] lcgState;
    int          mismatches;
    int          failures;

    memCtrlTop memCtrlTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int lenBytes(accessLenT len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // little-endian, bytes past n stay zero
    function automatic dataT refRead(addrT addr, int n);
        dataT value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = value | (dataT'(refMem[addr + addrT'(i)]) << (8 * i));
        end
        return value;
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    // starts on a rising edge; a store updates the reference right away
    task automatic startData(accessKindT kind, accessLenT len, addrT addr, dataT wdata);
        @(posedge clk);
        dataReq   <= 1'b1;
        dataKind  <= kind;
        dataLen   <= len;
        dataAddr  <= addr;
        dataWdata <= wdata;
        if (kind == KIND_STORE) begin
            for (int i = 0; i < lenBytes(len); i++) begin
                refMem[addr + addrT'(i)] = byteT'(wdata >> (8 * i));
            end
        end
    endtask

    // req was raised on the previous edge
    // latency counts edges from the one that first samples req
    task automatic handshake(input bit isData, output int latency);
        int edges;
        edges = 0;
        latency = -1;
        while (latency < 0 && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (isData ? dataAck : fetchAck) begin
                latency = edges - 1;
            end
        end
        @(posedge clk);
        if (isData) begin
            dataReq <= 1'b0;
        end else begin
            fetchReq <= 1'b0;
        end
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while ((isData ? dataAck : fetchAck) && edges < WAIT_LIMIT);
        if (latency < 0 || (isData ? dataAck : fetchAck)) begin
            $display("timeout at %0t ns: %s handshake did not complete", $time,
                     isData ? "data" : "fetch");
            failures++;
        end
    endtask

    // store, then read back as a word and at the store's own size
    task automatic storeLoadTest(accessLenT len);
        addrT addr;
        int   latency;
        addr = addrT'(nextRandom() >> 16);
        // fill the whole word first so zero extension shows
        startData(KIND_STORE, LEN_WORD, addr, nextRandom());
        handshake(1'b1, latency);
        startData(KIND_STORE, len, addr, nextRandom());
        handshake(1'b1, latency);
        checkValue("dataAck store latency", 32'(lenBytes(len) + 1), latency);
        startData(KIND_LOAD, LEN_WORD, addr, '0);
        handshake(1'b1, latency);
        checkValue("dataAck load latency", 32'd6, latency);
        checkValue("dataRdata", refRead(addr, 4), dataRdata);
        startData(KIND_LOAD, len, addr, '0);
        handshake(1'b1, latency);
        checkValue("dataAck load latency", 32'(lenBytes(len) + 2), latency);
        checkValue("dataRdata", refRead(addr, lenBytes(len)), dataRdata);
    endtask

    task automatic fetchTest();
        addrT addr;
        int   latency;
        addr = addrT'(nextRandom() >> 16);
        startData(KIND_STORE, LEN_WORD, addr, nextRandom());
        handshake(1'b1, latency);
        @(posedge clk);
        fetchReq  <= 1'b1;
        fetchAddr <= addr;
        handshake(1'b0, latency);
        checkValue("fetchAck latency", 32'd6, latency);
        checkValue("fetchInst", refRead(addr, `INST_BYTES), fetchInst);
    endtask

    // both clients ask on the same edge, data side must go first
    task automatic contentionTest();
        addrT fAddr;
        addrT dAddr;
        int   fetchLat;
        int   dataLat;
        fAddr = addrT'(nextRandom() >> 16);
        dAddr = addrT'(nextRandom() >> 16);
        startData(KIND_STORE, LEN_WORD, fAddr, nextRandom());
        handshake(1'b1, dataLat);
        startData(KIND_STORE, LEN_WORD, dAddr, nextRandom());
        handshake(1'b1, dataLat);
        startData(KIND_LOAD, LEN_WORD, dAddr, '0);
        fetchReq  <= 1'b1;
        fetchAddr <= fAddr;
        fork
            handshake(1'b1, dataLat);
            handshake(1'b0, fetchLat);
            begin
                // grant taken one edge after both busReq rise
                repeat (2) @(posedge clk);
                @(negedge clk);
                checkValue("owner", 32'(OWNER_DATA), 32'(memCtrlTop_i.memArbiter_i.owner));
            end
        join
        if (dataLat >= fetchLat) begin
            $display("fetchAck rose before dataAck while both clients were waiting");
            failures++;
        end
        checkValue("dataAck latency", 32'd6, dataLat);
        checkValue("dataRdata", refRead(dAddr, 4), dataRdata);
        checkValue("fetchInst", refRead(fAddr, `INST_BYTES), fetchInst);
    endtask

    task automatic stallTest(int cycles);
        addrT addr;
        int   latency;
        addr = addrT'(nextRandom() >> 16);
        startData(KIND_STORE, LEN_WORD, addr, nextRandom());
        handshake(1'b1, latency);
        startData(KIND_LOAD, LEN_WORD, addr, '0);
        fork
            handshake(1'b1, latency);
            begin
                // first byte already read when the stall starts
                repeat (3) @(posedge clk);
                stall <= 1'b1;
                repeat (cycles) @(posedge clk);
                stall <= 1'b0;
            end
        join
        checkValue("dataAck stalled latency", 32'(6 + cycles), latency);
        checkValue("dataRdata", refRead(addr, 4), dataRdata);
    endtask

    initial begin
        lcgState   = 32'h558bbeb9;
        mismatches = 0;
        failures   = 0;
        refMem     = '{default: '0};
        rst        = 1'b1;
        stall      = 1'b0;
        fetchReq   = 1'b0;
        fetchAddr  = '0;
        dataReq    = 1'b0;
        dataKind   = KIND_LOAD;
        dataLen    = LEN_BYTE;
        dataAddr   = '0;
        dataWdata  = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("fetchAck", 32'd0, 32'(fetchAck));
        checkValue("dataAck", 32'd0, 32'(dataAck));
        checkValue("ramWrite", 32'd0, 32'(memCtrlTop_i.ramWrite));
        checkValue("owner", 32'(OWNER_NONE), 32'(memCtrlTop_i.memArbiter_i.owner));

        storeLoadTest(LEN_WORD);
        storeLoadTest(LEN_HALF);
        storeLoadTest(LEN_BYTE);
        fetchTest();
        contentionTest();
        stallTest(1);
        stallTest(4);

        $display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/memTypesPkg.sv
logic/arbTypesPkg.sv
logic/byteCollector.sv
logic/fetchUnit.sv
logic/loadStoreUnit.sv
logic/memArbiter.sv
logic/byteRam.sv
logic/memCtrlTop.sv
dv/memCtrlTb.sv

//--- run.sh
#!/bin/sh
# build and run the memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module memCtrlTb \
    -f sim.f -o memCtrlSim \
    && ./obj_dir/memCtrlSim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q "Verification passed" sim.log 2>/dev/null && exit 0 || exit 1
